/* design/cpuPkg.sv */
//////////////////////////////////////////////////////////////////////
// cpu package for the integer execute path
// alu operation codes, opcode and funct values, exception bit
// positions and the two-view instruction word
//////////////////////////////////////////////////////////////////////
`default_nettype none

package cpuPkg;

    // operand and exception vector widths
    localparam int DATA_WIDTH = 32;
    localparam int EXC_WIDTH  = 8;

    // alu operations, variable shifts fold onto SLL/SRL/SRA
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_NOP
    } aluOpE;

    // one instruction word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } instrWordU;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    // funct field under OPC_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // exception vector bit positions
    localparam int EXC_INTERRUPT = 0;
    localparam int EXC_ADDR_IF   = 1;
    localparam int EXC_RESERVED  = 2;
    localparam int EXC_SYSCALL   = 3;
    localparam int EXC_BREAK     = 4;
    localparam int EXC_ERET      = 5;
    localparam int EXC_ADDR_WR   = 6;
    localparam int EXC_ADDR_RD   = 7;
    // overflow shares the eret bit, eret never reaches an alu op
    localparam int EXC_OVERFLOW  = 5;

endpackage

`default_nettype wire

/* design/instrDecoder.sv */
//////////////////////////////////////////////////////////////////////
// instruction decoder stage
// turns an instruction word into an alu op and two operands,
// flags unknown encodings, holds one item in a valid/ready register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module instrDecoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    output logic                          inReady,
    input  cpuPkg::instrWordU             instr,
    input  logic [cpuPkg::DATA_WIDTH-1:0] rsValue,
    input  logic [cpuPkg::DATA_WIDTH-1:0] rtValue,
    input  logic [cpuPkg::EXC_WIDTH-1:0]  excIn,
    output logic                          decValid,
    input  logic                          decReady,
    output cpuPkg::aluOpE                 decOp,
    output logic [cpuPkg::DATA_WIDTH-1:0] decA,
    output logic [cpuPkg::DATA_WIDTH-1:0] decB,
    output logic [cpuPkg::EXC_WIDTH-1:0]  decExc
);
    import cpuPkg::*;

    aluOpE                 nextOp;
    logic [DATA_WIDTH-1:0] nextA;
    logic [DATA_WIDTH-1:0] nextB;
    logic [EXC_WIDTH-1:0]  nextExc;
    logic                  reserved;
    logic                  accept;

    // decode, defaults are the register pair
    always_comb begin
        nextOp   = ALU_NOP;
        nextA    = rsValue;
        nextB    = rtValue;
        reserved = 1'b0;
        case (instr.i.opcode)
            OPC_SPECIAL: begin
                // R-type view for funct and shamt
                case (instr.r.funct)
                    FN_ADD:  nextOp = ALU_ADD;
                    FN_ADDU: nextOp = ALU_ADDU;
                    FN_SUB:  nextOp = ALU_SUB;
                    FN_SUBU: nextOp = ALU_SUBU;
                    FN_AND:  nextOp = ALU_AND;
                    FN_OR:   nextOp = ALU_OR;
                    FN_XOR:  nextOp = ALU_XOR;
                    FN_NOR:  nextOp = ALU_NOR;
                    FN_SLT:  nextOp = ALU_SLT;
                    FN_SLTU: nextOp = ALU_SLTU;
                    // variable shifts keep rs as amount
                    FN_SLLV: nextOp = ALU_SLL;
                    FN_SRLV: nextOp = ALU_SRL;
                    FN_SRAV: nextOp = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // fixed shift, amount from shamt
                        nextA = DATA_WIDTH'(instr.r.shamt);
                        if (instr.r.funct == FN_SLL) begin
                            nextOp = ALU_SLL;
                        end else if (instr.r.funct == FN_SRL) begin
                            nextOp = ALU_SRL;
                        end else begin
                            nextOp = ALU_SRA;
                        end
                    end
                    default: reserved = 1'b1;
                endcase
            end
            // sign-extended immediates
            OPC_ADDI: begin
                nextOp = ALU_ADD;
                nextB  = DATA_WIDTH'($signed(instr.i.imm16));
            end
            OPC_ADDIU: begin
                nextOp = ALU_ADDU;
                nextB  = DATA_WIDTH'($signed(instr.i.imm16));
            end
            OPC_SLTI: begin
                nextOp = ALU_SLT;
                nextB  = DATA_WIDTH'($signed(instr.i.imm16));
            end
            OPC_SLTIU: begin
                nextOp = ALU_SLTU;
                nextB  = DATA_WIDTH'($signed(instr.i.imm16));
            end
            // zero-extended immediates
            OPC_ANDI: begin
                nextOp = ALU_AND;
                nextB  = DATA_WIDTH'(instr.i.imm16);
            end
            OPC_ORI: begin
                nextOp = ALU_OR;
                nextB  = DATA_WIDTH'(instr.i.imm16);
            end
            OPC_XORI: begin
                nextOp = ALU_XOR;
                nextB  = DATA_WIDTH'(instr.i.imm16);
            end
            // lui is 0 | (imm << 16)
            OPC_LUI: begin
                nextOp = ALU_OR;
                nextA  = '0;
                nextB  = DATA_WIDTH'({instr.i.imm16, 16'h0000});
            end
            default: reserved = 1'b1;
        endcase
    end

    // incoming flags pass, reserved ORed in
    always_comb begin
        nextExc               = excIn;
        nextExc[EXC_RESERVED] = excIn[EXC_RESERVED] | reserved;
    end

    // single entry, refills in the cycle it drains
    assign inReady = !decValid || decReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (accept) begin
            decValid <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decOp  <= nextOp;
            decA   <= nextA;
            decB   <= nextB;
            decExc <= nextExc;
        end
    end

endmodule

`default_nettype wire

/* design/issueQueue.sv */
//////////////////////////////////////////////////////////////////////
// issue queue
// circular FIFO of decoded alu operations between decode and execute
//////////////////////////////////////////////////////////////////////
`default_nettype none

module issueQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          decValid,
    output logic                          decReady,
    input  cpuPkg::aluOpE                 decOp,
    input  logic [cpuPkg::DATA_WIDTH-1:0] decA,
    input  logic [cpuPkg::DATA_WIDTH-1:0] decB,
    input  logic [cpuPkg::EXC_WIDTH-1:0]  decExc,
    output logic                          qValid,
    input  logic                          qReady,
    output cpuPkg::aluOpE                 qOp,
    output logic [cpuPkg::DATA_WIDTH-1:0] qA,
    output logic [cpuPkg::DATA_WIDTH-1:0] qB,
    output logic [cpuPkg::EXC_WIDTH-1:0]  qExc
);
    import cpuPkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(QUEUE_DEPTH);

    aluOpE                 opMem  [QUEUE_DEPTH];
    logic [DATA_WIDTH-1:0] aMem   [QUEUE_DEPTH];
    logic [DATA_WIDTH-1:0] bMem   [QUEUE_DEPTH];
    logic [EXC_WIDTH-1:0]  excMem [QUEUE_DEPTH];
    logic [PTR_W-1:0]      wrPtr;
    logic [PTR_W-1:0]      rdPtr;
    logic [CNT_W-1:0]      count;
    logic                  push;
    logic                  pop;

    assign decReady = (count != FULL_COUNT);
    assign qValid   = (count != '0);
    assign push     = decValid && decReady;
    assign pop      = qValid && qReady;

    // head of queue
    assign qOp  = opMem[rdPtr];
    assign qA   = aMem[rdPtr];
    assign qB   = bMem[rdPtr];
    assign qExc = excMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[wrPtr]  <= decOp;
            aMem[wrPtr]   <= decA;
            bMem[wrPtr]   <= decB;
            excMem[wrPtr] <= decExc;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/aluExecute.sv */
//////////////////////////////////////////////////////////////////////
// alu execute stage
// computes the alu result and the overflow flag, registers them
// behind a valid/ready output
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluExecute (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          qValid,
    output logic                          qReady,
    input  cpuPkg::aluOpE                 qOp,
    input  logic [cpuPkg::DATA_WIDTH-1:0] qA,
    input  logic [cpuPkg::DATA_WIDTH-1:0] qB,
    input  logic [cpuPkg::EXC_WIDTH-1:0]  qExc,
    output logic                          outValid,
    input  logic                          outReady,
    output logic [cpuPkg::DATA_WIDTH-1:0] result,
    output logic [cpuPkg::EXC_WIDTH-1:0]  excOut
);
    import cpuPkg::*;

    localparam int MSB = DATA_WIDTH - 1;

    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] diff;
    logic [DATA_WIDTH-1:0] aluResult;
    logic [EXC_WIDTH-1:0]  nextExc;
    logic                  overflow;
    logic                  pop;

    assign sum  = qA + qB;
    assign diff = qA - qB;

    always_comb begin
        case (qOp)
            ALU_ADD, ALU_ADDU: aluResult = sum;
            ALU_SUB, ALU_SUBU: aluResult = diff;
            ALU_AND:  aluResult = qA & qB;
            ALU_OR:   aluResult = qA | qB;
            ALU_XOR:  aluResult = qA ^ qB;
            ALU_NOR:  aluResult = ~(qA | qB);
            // compares give 0 or 1
            ALU_SLT:  aluResult = DATA_WIDTH'($signed(qA) < $signed(qB));
            ALU_SLTU: aluResult = DATA_WIDTH'(qA < qB);
            // shift B by the low five bits of A
            ALU_SLL:  aluResult = qB << qA[4:0];
            ALU_SRL:  aluResult = qB >> qA[4:0];
            ALU_SRA:  aluResult = $signed(qB) >>> qA[4:0];
            // nop and anything else
            default:  aluResult = '0;
        endcase
    end

    // signed overflow, only add and sub trap
    always_comb begin
        case (qOp)
            ALU_ADD: overflow = (qA[MSB] == qB[MSB]) && (sum[MSB] != qA[MSB]);
            ALU_SUB: overflow = (qA[MSB] != qB[MSB]) && (diff[MSB] != qA[MSB]);
            default: overflow = 1'b0;
        endcase
    end

    always_comb begin
        nextExc               = qExc;
        nextExc[EXC_OVERFLOW] = qExc[EXC_OVERFLOW] | overflow;
    end

    // output register, takes a new item while being drained
    assign qReady = !outValid || outReady;
    assign pop    = qValid && qReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (pop) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result <= aluResult;
            excOut <= nextExc;
        end
    end

endmodule

`default_nettype wire

/* design/aluExecUnit.sv */
//////////////////////////////////////////////////////////////////////
// integer execute unit
// decoder, issue queue and alu stage chained by valid/ready
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluExecUnit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inValid,
    output logic                          inReady,
    input  cpuPkg::instrWordU             instr,
    input  logic [cpuPkg::DATA_WIDTH-1:0] rsValue,
    input  logic [cpuPkg::DATA_WIDTH-1:0] rtValue,
    input  logic [cpuPkg::EXC_WIDTH-1:0]  excIn,
    output logic                          outValid,
    input  logic                          outReady,
    output logic [cpuPkg::DATA_WIDTH-1:0] result,
    output logic [cpuPkg::EXC_WIDTH-1:0]  excOut
);
    import cpuPkg::*;

    // decoder to queue
    logic                  decValid;
    logic                  decReady;
    aluOpE                 decOp;
    logic [DATA_WIDTH-1:0] decA;
    logic [DATA_WIDTH-1:0] decB;
    logic [EXC_WIDTH-1:0]  decExc;

    // queue to alu
    logic                  qValid;
    logic                  qReady;
    aluOpE                 qOp;
    logic [DATA_WIDTH-1:0] qA;
    logic [DATA_WIDTH-1:0] qB;
    logic [EXC_WIDTH-1:0]  qExc;

    instrDecoder uDecoder (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .rsValue  (rsValue),
        .rtValue  (rtValue),
        .excIn    (excIn),
        .decValid (decValid),
        .decReady (decReady),
        .decOp    (decOp),
        .decA     (decA),
        .decB     (decB),
        .decExc   (decExc)
    );

    issueQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uQueue (
        .clk      (clk),
        .rst      (rst),
        .decValid (decValid),
        .decReady (decReady),
        .decOp    (decOp),
        .decA     (decA),
        .decB     (decB),
        .decExc   (decExc),
        .qValid   (qValid),
        .qReady   (qReady),
        .qOp      (qOp),
        .qA       (qA),
        .qB       (qB),
        .qExc     (qExc)
    );

    aluExecute uAlu (
        .clk      (clk),
        .rst      (rst),
        .qValid   (qValid),
        .qReady   (qReady),
        .qOp      (qOp),
        .qA       (qA),
        .qB       (qB),
        .qExc     (qExc),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result),
        .excOut   (excOut)
    );

endmodule

`default_nettype wire

/* verif/aluExecUnit_assert.sv */
//////////////////////////////////////////////////////////////////////
// handshake checks for the integer execute unit
// bound into the top level, watches reset and output stability
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluExecUnitAssert (
    input logic                          clk,
    input logic                          rst,
    input logic                          inReady,
    input logic                          outValid,
    input logic                          outReady,
    input logic [cpuPkg::DATA_WIDTH-1:0] result,
    input logic [cpuPkg::EXC_WIDTH-1:0]  excOut
);
    // failures seen, read by the testbench at the end
    int failCount = 0;

    // a reset edge leaves the output register empty
    assert property (@(posedge clk) rst |=> !outValid)
        else begin
            failCount++;
            $error("outValid high after a reset edge");
        end

    // stalled output holds valid and data
    assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(result) && $stable(excOut)))
        else begin
            failCount++;
            $error("output changed while stalled");
        end

    // ready is always driven once out of reset
    assert property (@(posedge clk) disable iff (rst) !$isunknown(inReady))
        else begin
            failCount++;
            $error("inReady unknown after reset");
        end

endmodule

bind aluExecUnit aluExecUnitAssert uAssert (
    .clk      (clk),
    .rst      (rst),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .result   (result),
    .excOut   (excOut)
);

`default_nettype wire

/* verif/aluExecUnitTb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the integer execute unit
// vectors from a hex file, random output stall, in-order checking
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aluExecUnitTb;
    import cpuPkg::*;

    localparam int NUM_VECS     = 29;
    localparam int FIELDS       = 6;
    localparam int TIMEOUT      = 200;
    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] SEED = 32'd91;

    logic                  clk;
    logic                  rst;
    logic                  inValid;
    logic                  inReady;
    instrWordU             instr;
    logic [DATA_WIDTH-1:0] rsValue;
    logic [DATA_WIDTH-1:0] rtValue;
    logic [EXC_WIDTH-1:0]  excIn;
    logic                  outValid;
    logic                  outReady;
    logic [DATA_WIDTH-1:0] result;
    logic [EXC_WIDTH-1:0]  excOut;

    // six words per vector in the order instr rs rt excIn result excOut
    logic [31:0]           vecMem [NUM_VECS*FIELDS];
    logic [31:0]           rngState;
    logic [DATA_WIDTH-1:0] expResult;
    logic [EXC_WIDTH-1:0]  expExc;
    int                    outCount    = 0;
    int                    valueErrors = 0;
    int                    otherErrors = 0;

    aluExecUnit #(
        .QUEUE_DEPTH (4)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .rsValue  (rsValue),
        .rtValue  (rtValue),
        .excIn    (excIn),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result),
        .excOut   (excOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 32-bit xorshift step
    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // sink ready about 60 % of cycles
    always @(posedge clk) begin
        rngState <= nextRandom(rngState);
        outReady <= (rngState % 100) < 60;
    end

    // offer one vector and hold it until the decoder takes it
    task automatic sendVector(input int idx, output bit timedOut);
        int waitCycles;
        waitCycles = 0;
        inValid <= 1'b1;
        instr   <= vecMem[idx*FIELDS];
        rsValue <= vecMem[idx*FIELDS+1];
        rtValue <= vecMem[idx*FIELDS+2];
        excIn   <= vecMem[idx*FIELDS+3][EXC_WIDTH-1:0];
        @(posedge clk);
        // inReady here is the value seen by this edge
        while (!inReady && waitCycles < TIMEOUT) begin
            @(posedge clk);
            waitCycles++;
        end
        timedOut = !inReady;
    endtask

    // expected values come straight from the vector file
    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            assert (outCount < NUM_VECS) else begin
                otherErrors++;
                $display("extra result %h came out after the last vector at %0t",
                         result, $time);
            end
            if (outCount < NUM_VECS) begin
                expResult = vecMem[outCount*FIELDS+4];
                expExc    = vecMem[outCount*FIELDS+5][EXC_WIDTH-1:0];
                assert (result == expResult) else begin
                    valueErrors++;
                    $display("error: time %0t vector %0d result expected %h got %h",
                             $time, outCount, expResult, result);
                end
                assert (excOut == expExc) else begin
                    valueErrors++;
                    $display("error: time %0t vector %0d excOut expected %h got %h",
                             $time, outCount, expExc, excOut);
                end
            end
            outCount++;
        end
    end

    initial begin
        bit timedOut;
        int waitCycles;
        int i;
        timedOut = 1'b0;
        rst      = 1'b1;
        inValid  = 1'b0;
        instr    = '0;
        rsValue  = '0;
        rtValue  = '0;
        excIn    = '0;
        outReady = 1'b0;
        rngState = SEED;
        $readmemh("verif/aluTests.mem", vecMem);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // back to back until done or the input stalls for good
        for (i = 0; i < NUM_VECS && !timedOut; i++) begin
            sendVector(i, timedOut);
        end
        inValid <= 1'b0;
        if (timedOut) begin
            otherErrors++;
            $display("timeout: the unit stopped taking inputs at vector %0d", i - 1);
        end
        // drain
        waitCycles = 0;
        while (outCount < NUM_VECS && waitCycles < TIMEOUT) begin
            @(posedge clk);
            waitCycles++;
        end
        if (outCount < NUM_VECS) begin
            otherErrors++;
            $display("timeout: only %0d of %0d results came out", outCount, NUM_VECS);
        end
        // short window to catch duplicates
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d other, %0d assertion",
                 valueErrors, otherErrors, dut.uAssert.failCount);
        if (valueErrors == 0 && otherErrors == 0 && dut.uAssert.failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/aluTests.mem */
// instr    rs       rt       excIn result   excOut   (hex, one vector per line)
// excIn/excOut bits: 2 reserved instruction, 5 overflow, others pass through
00221820 7FFFFFFF 00000001 00 80000000 20
00221820 00000005 FFFFFFFD 81 00000002 81
00221822 80000000 00000001 01 7FFFFFFF 21
00221822 00000003 00000005 00 FFFFFFFE 00
00221821 7FFFFFFF 00000001 00 80000000 00
00221823 80000000 00000001 00 7FFFFFFF 00
2022FFFF 00000010 00000000 00 0000000F 00
20220001 7FFFFFFF 00000000 00 80000000 20
24220001 7FFFFFFF 00000000 00 80000000 00
00221824 F0F0F0F0 FF00FF00 00 F000F000 00
00221825 F0F0F0F0 FF00FF00 00 FFF0FFF0 00
00221826 F0F0F0F0 FF00FF00 00 0FF00FF0 00
00221827 F0F0F0F0 FF00FF00 00 000F000F 00
30228F0F FFFFFFFF 00000000 00 00008F0F 00
34228000 12340000 00000000 00 12348000 00
3822FFFF FFFF0000 00000000 00 FFFFFFFF 00
3C22ABCD FFFFFFFF 00000000 00 ABCD0000 00
00221900 FFFFFFFF 0000000F 00 000000F0 00
00221A02 FFFFFFFF 80000000 00 00800000 00
00221903 00000000 80000000 00 F8000000 00
00221804 00000024 00000001 00 00000010 00
00221806 00000021 80000000 00 40000000 00
00221807 FFFFFFE3 80000000 00 F0000000 00
0022182A FFFFFFFF 00000001 00 00000001 00
0022182B FFFFFFFF 00000001 00 00000000 00
2822FFFF 00000001 00000000 00 00000000 00
2C22FFFF 00000001 00000000 00 00000001 00
FC220000 12345678 9ABCDEF0 00 00000000 04
00221801 12345678 9ABCDEF0 10 00000000 14

/* verilog.f */
design/cpuPkg.sv
design/instrDecoder.sv
design/issueQueue.sv
design/aluExecute.sv
design/aluExecUnit.sv
verif/aluExecUnit_assert.sv
verif/aluExecUnitTb.sv

/* run.sh */
#!/bin/sh
# build and run the execute unit testbench, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module aluExecUnitTb -f verilog.f \
    && ./obj_dir/ValuExecUnitTb +verilator+error+limit+1000 \
    | awk '{ print } /Simulation finished: PASS/ { found = 1 } END { exit !found }' \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
